// ==== src/core_pkg.sv ====
package core_pkg;

    typedef logic [31:0] word_t;     // data or instruction word
    typedef logic [31:0] pc_t;       // byte address of an instruction
    typedef logic [4:0]  reg_idx_t;  // register number
    typedef logic [15:0] apb_addr_t; // apb byte address

    // run control register, bit 0 starts or stops the core
    localparam apb_addr_t ctrl_addr = 16'h1000;

endpackage

// ==== src/isa_pkg.sv ====
package isa_pkg;

    localparam logic [5:0] op_special = 6'h00; // r-type, see funct
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;

    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_slt  = 6'h2a;

    typedef enum logic [2:0] {
        alu_add, // addu, addiu
        alu_sub, // subu
        alu_and,
        alu_or,  // or, ori
        alu_slt, // signed compare
        alu_lui  // operand b moved to the upper half
    } alu_op_e;

endpackage

// ==== src/pipe_ctrl.sv ====
`timescale 1ns/1ns

module pipe_ctrl (
    input  logic aclk,
    input  logic rst_n,
    input  logic start_req,
    input  logic stop_req,
    input  logic raw_stall,
    input  logic branch_taken,
    output logic running,
    output logic if_wr,
    output logic id_wr,
    output logic id_flush,
    output logic ex_flush,
    output logic pc_clear
);

    typedef enum logic {
        idle,
        run
    } ctrl_state_e;

    ctrl_state_e state;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle:    if (start_req) state <= run;
                run:     if (stop_req) state <= idle;
                default: state <= idle;
            endcase
        end
    end

    assign running  = (state == run);
    assign pc_clear = start_req;                            // restart always begins at pc 0
    assign if_wr    = running & (branch_taken | ~raw_stall); // branch wins over stall
    assign id_wr    = running;
    assign id_flush = branch_taken;
    // stall and stopped core both feed bubbles into execute
    assign ex_flush = pc_clear | ~running | branch_taken | raw_stall;

    a_no_fetch_idle: assert property (@(posedge aclk) disable iff (!rst_n)
        stop_req |=> !if_wr);

    a_clear_on_start: assert property (@(posedge aclk) disable iff (!rst_n)
        pc_clear |-> start_req ##1 running);

endmodule

// ==== src/imem_apb.sv ====
`timescale 1ns/1ns

module imem_apb import core_pkg::*; #(
    parameter int imem_depth = 64
) (
    input  logic      aclk,
    input  logic      rst_n,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  word_t     pwdata,
    output word_t     prdata,
    output logic      pready,
    output logic      pslverr,
    input  logic      running,
    output logic      start_req,
    output logic      stop_req,
    input  pc_t       fetch_addr,
    output word_t     fetch_data
);

    localparam int aw        = $clog2(imem_depth);
    localparam int ram_bytes = imem_depth * 4;

    word_t mem [imem_depth];

    logic access;
    logic ram_hit;
    logic ctrl_hit;

    assign access   = psel & penable;              // access phase
    assign ram_hit  = int'(paddr) < ram_bytes;
    assign ctrl_hit = (paddr == ctrl_addr);

    always_ff @(posedge aclk) begin
        if (access && pwrite && ram_hit && !running) begin
            mem[paddr[aw+1:2]] <= pwdata;
        end
    end

    assign pready    = 1'b1;                       // no wait states
    assign pslverr   = access & (~(ram_hit | ctrl_hit) | (ram_hit & pwrite & running));
    assign start_req = access & pwrite & ctrl_hit & pwdata[0];
    assign stop_req  = access & pwrite & ctrl_hit & ~pwdata[0];

    always_comb begin
        prdata = '0;
        if (ram_hit) begin
            prdata = mem[paddr[aw+1:2]];
        end else if (ctrl_hit) begin
            prdata = {31'b0, running};
        end
    end

    assign fetch_data = mem[fetch_addr[aw+1:2]]; // async read for fetch

    a_penable_psel: assert property (@(posedge aclk) disable iff (!rst_n)
        penable |-> psel);

endmodule

// ==== src/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage import core_pkg::*; #(
    parameter int imem_depth = 64
) (
    input  logic  aclk,
    input  logic  rst_n,
    input  logic  if_wr,
    input  logic  id_flush,
    input  logic  pc_clear,
    input  logic  branch_taken,
    input  pc_t   branch_target,
    output pc_t   fetch_addr,
    input  word_t fetch_data,
    output word_t id_instr,
    output pc_t   id_pc,
    output logic  id_valid
);

    localparam pc_t pc_mask = pc_t'(imem_depth * 4 - 1); // wrap at end of memory

    pc_t pc;
    pc_t pc_next;

    assign pc_next    = (branch_taken ? branch_target : pc + 32'd4) & pc_mask;
    assign fetch_addr = pc;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pc_clear) begin
            pc <= '0;
        end else if (if_wr) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else if (pc_clear || id_flush) begin
            id_valid <= 1'b0;  // wrong-path fetch dropped
        end else if (if_wr) begin
            id_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (if_wr) begin
            id_instr <= fetch_data;
            id_pc    <= pc;
        end
    end

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage import core_pkg::*, isa_pkg::*; (
    input  logic     aclk,
    input  logic     rst_n,
    input  word_t    id_instr,
    input  pc_t      id_pc,
    input  logic     id_valid,
    input  logic     id_wr,
    input  logic     ex_flush,
    input  logic     wb_we,
    input  reg_idx_t wb_num,
    input  word_t    wb_data,
    output logic     raw_stall,
    output logic     ex_valid,
    output pc_t      ex_pc,
    output alu_op_e  ex_op,
    output word_t    ex_a,
    output word_t    ex_b,
    output word_t    ex_imm,
    output reg_idx_t ex_dst,
    output logic     ex_is_beq,
    output logic     ex_is_bne
);

    word_t    regs [32];
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    word_t    rs_val;
    word_t    rt_val;
    word_t    sign_imm;
    word_t    zero_imm;

    alu_op_e  dec_op;
    reg_idx_t dec_dst;
    logic     dec_use_imm;
    logic     dec_zext;
    logic     dec_uses_rs;
    logic     dec_uses_rt;
    logic     dec_beq;
    logic     dec_bne;

    assign rs       = id_instr[25:21];
    assign rt       = id_instr[20:16];
    assign rd       = id_instr[15:11];
    assign sign_imm = {{16{id_instr[15]}}, id_instr[15:0]};
    assign zero_imm = {16'b0, id_instr[15:0]};

    always_comb begin
        dec_op      = alu_add;
        dec_dst     = '0;      // no destination means no-op
        dec_use_imm = 1'b0;
        dec_zext    = 1'b0;
        dec_uses_rs = 1'b0;
        dec_uses_rt = 1'b0;
        dec_beq     = 1'b0;
        dec_bne     = 1'b0;
        case (id_instr[31:26])
            op_special: begin
                dec_uses_rs = 1'b1;
                dec_uses_rt = 1'b1;
                dec_dst     = rd;
                case (id_instr[5:0])
                    fn_addu: dec_op = alu_add;
                    fn_subu: dec_op = alu_sub;
                    fn_and:  dec_op = alu_and;
                    fn_or:   dec_op = alu_or;
                    fn_slt:  dec_op = alu_slt;
                    default: dec_dst = '0; // unsupported funct
                endcase
            end
            op_addiu: begin
                dec_uses_rs = 1'b1;
                dec_use_imm = 1'b1;
                dec_dst     = rt;
            end
            op_ori: begin
                dec_op      = alu_or;
                dec_uses_rs = 1'b1;
                dec_use_imm = 1'b1;
                dec_zext    = 1'b1;
                dec_dst     = rt;
            end
            op_lui: begin
                dec_op      = alu_lui;
                dec_use_imm = 1'b1;
                dec_zext    = 1'b1;
                dec_dst     = rt;
            end
            op_beq, op_bne: begin
                dec_uses_rs = 1'b1;
                dec_uses_rt = 1'b1;
                dec_beq     = (id_instr[31:26] == op_beq);
                dec_bne     = (id_instr[31:26] == op_bne);
            end
            default: ;
        endcase
    end

    // write-first, so a value retiring this cycle is seen here
    assign rs_val = (rs == '0) ? '0 : (wb_we && wb_num == rs) ? wb_data : regs[rs];
    assign rt_val = (rt == '0) ? '0 : (wb_we && wb_num == rt) ? wb_data : regs[rt];

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we) begin
            regs[wb_num] <= wb_data;
        end
    end

    assign raw_stall = id_valid & ex_valid & (ex_dst != '0) &
                       ((dec_uses_rs & (rs == ex_dst)) | (dec_uses_rt & (rt == ex_dst)));

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (ex_flush) begin
            ex_valid <= 1'b0;   // bubble
        end else if (id_wr) begin
            ex_valid <= id_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (id_wr) begin
            ex_pc     <= id_pc;
            ex_op     <= dec_op;
            ex_a      <= rs_val;
            ex_b      <= dec_use_imm ? (dec_zext ? zero_imm : sign_imm) : rt_val;
            ex_imm    <= sign_imm; // branch offset
            ex_dst    <= dec_dst;
            ex_is_beq <= dec_beq;
            ex_is_bne <= dec_bne;
        end
    end

    a_no_r0_write: assert property (@(posedge aclk) disable iff (!rst_n)
        wb_we |-> (wb_num != '0));

endmodule

// ==== src/exec_stage.sv ====
`timescale 1ns/1ns

module exec_stage import core_pkg::*, isa_pkg::*; (
    input  logic     aclk,
    input  logic     rst_n,
    input  logic     ex_valid,
    input  pc_t      ex_pc,
    input  alu_op_e  ex_op,
    input  word_t    ex_a,
    input  word_t    ex_b,
    input  word_t    ex_imm,
    input  reg_idx_t ex_dst,
    input  logic     ex_is_beq,
    input  logic     ex_is_bne,
    output logic     branch_taken,
    output pc_t      branch_target,
    output logic     wb_we,
    output reg_idx_t wb_num,
    output word_t    wb_data,
    output pc_t      wb_pc
);

    word_t alu_res;
    logic  ops_equal;

    always_comb begin
        case (ex_op)
            alu_add: alu_res = ex_a + ex_b;
            alu_sub: alu_res = ex_a - ex_b;
            alu_and: alu_res = ex_a & ex_b;
            alu_or:  alu_res = ex_a | ex_b;
            alu_slt: alu_res = {31'b0, $signed(ex_a) < $signed(ex_b)};
            alu_lui: alu_res = {ex_b[15:0], 16'b0};
            default: alu_res = '0;
        endcase
    end

    assign ops_equal     = (ex_a == ex_b);
    assign branch_taken  = ex_valid & ((ex_is_beq & ops_equal) | (ex_is_bne & ~ops_equal));
    assign branch_target = ex_pc + 32'd4 + {ex_imm[29:0], 2'b00}; // relative to delay slot addr

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= ex_valid && (ex_dst != '0); // r0 and branches never retire a write
        end
    end

    always_ff @(posedge aclk) begin
        wb_num  <= ex_dst;
        wb_data <= alu_res;
        wb_pc   <= ex_pc;
    end

endmodule

// ==== src/core_top.sv ====
`timescale 1ns/1ns

module core_top import core_pkg::*, isa_pkg::*; #(
    parameter int imem_depth = 64 // words, power of two
) (
    input  logic      aclk,
    input  logic      rst_n,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  word_t     pwdata,
    output word_t     prdata,
    output logic      pready,
    output logic      pslverr,
    output logic      trace_valid,
    output pc_t       trace_pc,
    output reg_idx_t  trace_num,
    output word_t     trace_data,
    output logic      running
);

    logic     start_req;
    logic     stop_req;
    logic     raw_stall;
    logic     branch_taken;
    pc_t      branch_target;
    logic     if_wr;
    logic     id_wr;
    logic     id_flush;
    logic     ex_flush;
    logic     pc_clear;
    pc_t      fetch_addr;
    word_t    fetch_data;
    word_t    id_instr;
    pc_t      id_pc;
    logic     id_valid;
    logic     ex_valid;
    pc_t      ex_pc;
    alu_op_e  ex_op;
    word_t    ex_a;
    word_t    ex_b;
    word_t    ex_imm;
    reg_idx_t ex_dst;
    logic     ex_is_beq;
    logic     ex_is_bne;
    logic     wb_we;
    reg_idx_t wb_num;
    word_t    wb_data;
    pc_t      wb_pc;

    // writeback doubles as the trace port
    assign trace_valid = wb_we;
    assign trace_pc    = wb_pc;
    assign trace_num   = wb_num;
    assign trace_data  = wb_data;

    pipe_ctrl u_pipe_ctrl (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .start_req    (start_req),
        .stop_req     (stop_req),
        .raw_stall    (raw_stall),
        .branch_taken (branch_taken),
        .running      (running),
        .if_wr        (if_wr),
        .id_wr        (id_wr),
        .id_flush     (id_flush),
        .ex_flush     (ex_flush),
        .pc_clear     (pc_clear)
    );

    imem_apb #(.imem_depth(imem_depth)) u_imem_apb (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .running    (running),
        .start_req  (start_req),
        .stop_req   (stop_req),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data)
    );

    fetch_stage #(.imem_depth(imem_depth)) u_fetch_stage (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .if_wr         (if_wr),
        .id_flush      (id_flush),
        .pc_clear      (pc_clear),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .fetch_addr    (fetch_addr),
        .fetch_data    (fetch_data),
        .id_instr      (id_instr),
        .id_pc         (id_pc),
        .id_valid      (id_valid)
    );

    decode_stage u_decode_stage (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .id_instr  (id_instr),
        .id_pc     (id_pc),
        .id_valid  (id_valid),
        .id_wr     (id_wr),
        .ex_flush  (ex_flush),
        .wb_we     (wb_we),
        .wb_num    (wb_num),
        .wb_data   (wb_data),
        .raw_stall (raw_stall),
        .ex_valid  (ex_valid),
        .ex_pc     (ex_pc),
        .ex_op     (ex_op),
        .ex_a      (ex_a),
        .ex_b      (ex_b),
        .ex_imm    (ex_imm),
        .ex_dst    (ex_dst),
        .ex_is_beq (ex_is_beq),
        .ex_is_bne (ex_is_bne)
    );

    exec_stage u_exec_stage (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .ex_valid      (ex_valid),
        .ex_pc         (ex_pc),
        .ex_op         (ex_op),
        .ex_a          (ex_a),
        .ex_b          (ex_b),
        .ex_imm        (ex_imm),
        .ex_dst        (ex_dst),
        .ex_is_beq     (ex_is_beq),
        .ex_is_bne     (ex_is_bne),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .wb_we         (wb_we),
        .wb_num        (wb_num),
        .wb_data       (wb_data),
        .wb_pc         (wb_pc)
    );

endmodule

// ==== testbench/tb_clkgen.sv ====
`timescale 1ns/1ns

module tb_clkgen #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 8
) (
    output logic aclk,
    output logic rst_n
);

    initial begin
        aclk = 1'b0;
        forever #half_period aclk = ~aclk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge aclk);
        #2 rst_n = 1'b1; // released just after the edge
    end

endmodule

// ==== testbench/tb_core.sv ====
`timescale 1ns/1ns

module tb_core import core_pkg::*; ();

    logic      aclk;
    logic      rst_n;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    word_t     pwdata;
    word_t     prdata;
    logic      pready;
    logic      pslverr;
    logic      trace_valid;
    pc_t       trace_pc;
    reg_idx_t  trace_num;
    word_t     trace_data;
    logic      running;

    pc_t       exp_pc[$];   // expected trace, oldest first
    reg_idx_t  exp_num[$];
    word_t     exp_data[$];
    int        fail_count  = 0;
    int        cycle_limit = 0;

    tb_clkgen u_clkgen (
        .aclk  (aclk),
        .rst_n (rst_n)
    );

    core_top #(.imem_depth(64)) dut0 (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .trace_valid (trace_valid),
        .trace_pc    (trace_pc),
        .trace_num   (trace_num),
        .trace_data  (trace_data),
        .running     (running)
    );

    task automatic abort_run();
        fail_count++;
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        $display("[FAIL] %s got %h expected %h", name, got, exp);
        abort_run();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        abort_run();
    endtask

    task automatic apb_transfer(input apb_addr_t addr, input logic wr, input word_t wdata,
                                output word_t rdata, output logic err);
        repeat ($urandom % 3) @(posedge aclk); // random idle gap
        @(posedge aclk);
        #2;
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge aclk);
        #2;
        penable = 1'b1;
        #8;
        while (pready !== 1'b1) begin // mid-cycle sampling
            @(posedge aclk);
            #10;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge aclk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic finish_case();
        int waited;
        waited = 0;
        while (exp_pc.size() > 0 && waited < 300) begin
            @(negedge aclk);
            waited++;
        end
        assert (exp_pc.size() == 0)
            else report_problem("expected trace entries never retired before end of case");
        repeat (12) @(negedge aclk); // window for stray retirements
    endtask

    always @(negedge aclk) begin
        if (trace_valid === 1'b1) begin
            assert (exp_pc.size() > 0)
                else report_problem("trace entry retired with none expected");
            if (exp_pc.size() > 0) begin
                assert (trace_pc === exp_pc[0])
                    else report_mismatch("trace_pc", trace_pc, exp_pc[0]);
                assert (trace_num === exp_num[0])
                    else report_mismatch("trace_num", trace_num, exp_num[0]);
                assert (trace_data === exp_data[0])
                    else report_mismatch("trace_data", trace_data, exp_data[0]);
                void'(exp_pc.pop_front());
                void'(exp_num.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    initial begin
        wait (cycle_limit > 0);
        repeat (cycle_limit) @(posedge aclk);
        report_problem("watchdog expired before the cases file was finished");
    end

    initial begin
        int                 fd;
        int                 code;
        int                 n_lines;
        logic [7:0]         kind;
        logic [8*160-1:0]   line_buf;
        word_t              addr;
        word_t              data;
        word_t              exp_val;
        word_t              got_data;
        logic               got_err;

        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        void'($urandom(81918));

        fd = $fopen("testbench/core_cases.txt", "r");
        assert (fd != 0) else report_problem("cannot open testbench/core_cases.txt");
        n_lines = 0;
        while ($fgets(line_buf, fd) != 0) begin
            n_lines++;
        end
        $fclose(fd);
        cycle_limit = n_lines * 40 + 200;

        fd = $fopen("testbench/core_cases.txt", "r");
        wait (rst_n === 1'b1);
        @(posedge aclk);
        while ($fscanf(fd, "%s", kind) == 1) begin
            case (kind)
                "#": void'($fgets(line_buf, fd));
                "w": begin
                    code = $fscanf(fd, "%h %h %h", addr, data, exp_val);
                    assert (code == 3) else report_problem("malformed w line in the cases file");
                    apb_transfer(addr[15:0], 1'b1, data, got_data, got_err);
                    assert (got_err === exp_val[0])
                        else report_mismatch("pslverr", got_err, exp_val);
                end
                "r": begin
                    code = $fscanf(fd, "%h %h", addr, exp_val);
                    assert (code == 2) else report_problem("malformed r line in the cases file");
                    apb_transfer(addr[15:0], 1'b0, '0, got_data, got_err);
                    assert (got_data === exp_val)
                        else report_mismatch("prdata", got_data, exp_val);
                end
                "s": begin
                    code = $fscanf(fd, "%h", data);
                    assert (code == 1) else report_problem("malformed s line in the cases file");
                    apb_transfer(ctrl_addr, 1'b1, data, got_data, got_err);
                    assert (got_err === 1'b0)
                        else report_mismatch("pslverr", got_err, 32'h0);
                    // run flag follows one cycle after the control write
                    assert (running === data[0])
                        else report_mismatch("running", running, {31'b0, data[0]});
                end
                "t": begin
                    code = $fscanf(fd, "%h %h %h", addr, data, exp_val);
                    assert (code == 3) else report_problem("malformed t line in the cases file");
                    exp_pc.push_back(addr);
                    exp_num.push_back(data[4:0]);
                    exp_data.push_back(exp_val);
                end
                "e": finish_case();
                default: report_problem("unknown line kind in testbench/core_cases.txt");
            endcase
        end
        $fclose(fd);

        if (fail_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

// ==== testbench/core_cases.txt ====
# w addr data err | r addr data | s run | t pc reg data | e ends a case
# all fields in hex, addresses are apb byte addresses
# case 1: ram write and read back, unmapped accesses
w 0000 12345678 0
r 0000 12345678
w 0100 0000abcd 1
r 0100 00000000
w 2000 00000001 1
r 1000 00000000
e
# case 2: straight-line alu program with dependent pairs and an r0 write
w 0000 24010005 0
w 0004 340200f0 0
w 0008 3c031234 0
w 000c 00222021 0
w 0010 00812823 0
w 0014 00a33024 0
w 0018 00a33825 0
w 001c 00a7402a 0
w 0020 24000007 0
w 0024 240affff 0
w 0028 0141582a 0
w 002c 1000ffff 0
s 1
t 00000000 01 00000005
t 00000004 02 000000f0
t 00000008 03 12340000
t 0000000c 04 000000f5
t 00000010 05 000000f0
t 00000014 06 00000000
t 00000018 07 123400f0
t 0000001c 08 00000001
t 00000024 0a ffffffff
t 00000028 0b 00000001
w 0000 ffffffff 1
r 0000 24010005
r 1000 00000001
e
# case 3: stop, reload a branch program, restart with registers kept
s 0
r 1000 00000000
w 0000 10220002 0
w 0004 242c0001 0
w 0008 15810002 0
w 000c 240d0011 0
w 0010 240e0022 0
w 0014 10c00002 0
w 0018 240d0033 0
w 001c 240e0044 0
w 0020 00ec7821 0
w 0024 1000ffff 0
s 1
t 00000004 0c 00000006
t 00000020 0f 123400f6
r 1000 00000001
e

// ==== flist.f ====
src/core_pkg.sv
src/isa_pkg.sv
src/pipe_ctrl.sv
src/imem_apb.sv
src/fetch_stage.sv
src/decode_stage.sv
src/exec_stage.sv
src/core_top.sv
testbench/tb_clkgen.sv
testbench/tb_core.sv
